/* hdl/gpr_file.sv */
`timescale 1ns/100ps

module gpr_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // write port
    input  logic                            we,
    input  logic [rv_core_pkg::REG_IDX_W-1:0] waddr,
    input  logic [rv_core_pkg::XLEN-1:0]      wdata,

    // store base read port
    input  logic [rv_core_pkg::REG_IDX_W-1:0] raddr_a,
    output logic [rv_core_pkg::XLEN-1:0]      rdata_a,

    // debug read port
    input  logic [rv_core_pkg::REG_IDX_W-1:0] raddr_b,
    output logic [rv_core_pkg::XLEN-1:0]      rdata_b
);

    logic [rv_core_pkg::XLEN-1:0] regs [NUM_REGS];

    logic wr_ok;
    logic rd_ok_a;
    logic rd_ok_b;

    // x0 is hardwired, indices past the file are ignored
    assign wr_ok   = we && (waddr != '0) && (32'(waddr) < NUM_REGS);
    assign rd_ok_a = (raddr_a != '0) && (32'(raddr_a) < NUM_REGS);
    assign rd_ok_b = (raddr_b != '0) && (32'(raddr_b) < NUM_REGS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr] <= wdata;
        end
    end

    // both reads are combinational
    assign rdata_a = rd_ok_a ? regs[raddr_a] : '0;
    assign rdata_b = rd_ok_b ? regs[raddr_b] : '0; // seen by the harness

endmodule

/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

    // one strobe bit per data byte
    parameter int STRB_W = 8;

    // store writer states, in the order they are walked
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WRITE = 2'd1, // request held until accepted
        ST_WRESP = 2'd2, // waiting for the acknowledge
        ST_DONE  = 2'd3  // one cycle completion
    } st_state_e;

endpackage

/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

    // datapath and register index widths
    parameter int XLEN      = 64;
    parameter int REG_IDX_W = 5;

    // how a result is shaped before it reaches the register file
    typedef enum logic [1:0] {
        EXT_NONE   = 2'd0, // full 64 bits
        EXT_SEXT_W = 2'd1, // lw, addw, divw and friends
        EXT_ZEXT_W = 2'd2, // lwu
        EXT_SEXT_H = 2'd3  // lh
    } ext_kind_e;

    // result source for writeback
    typedef enum logic {
        SRC_EX  = 1'b0,
        SRC_MEM = 1'b1
    } res_src_e;

endpackage

/* hdl/store_writer.sv */
`timescale 1ns/100ps

module store_writer (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                is_store,
    input  logic [rv_core_pkg::XLEN-1:0]        rs1_data,
    input  logic [31:0]                         st_imm,
    input  logic [rv_core_pkg::XLEN-1:0]        st_data,
    input  logic [mem_bus_pkg::STRB_W-1:0]      st_strb,

    // write bus
    input  logic                                wr_done,
    input  logic                                wr_resp,
    output logic                                wr_req,
    output logic [rv_core_pkg::XLEN-1:0]        wr_addr,
    output logic [rv_core_pkg::XLEN-1:0]        wr_data,
    output logic [mem_bus_pkg::STRB_W-1:0]      wr_strb,

    output logic                                store_done,
    output logic                                store_busy
);

    mem_bus_pkg::st_state_e state;
    mem_bus_pkg::st_state_e state_nxt;

    logic [rv_core_pkg::XLEN-1:0] st_addr;

    // base plus sign extended offset
    assign st_addr = rs1_data + {{(rv_core_pkg::XLEN-32){st_imm[31]}}, st_imm};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_bus_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mem_bus_pkg::ST_IDLE: begin
                if (is_store) begin
                    state_nxt = mem_bus_pkg::ST_WRITE;
                end
            end
            mem_bus_pkg::ST_WRITE: begin
                if (wr_done) begin
                    state_nxt = mem_bus_pkg::ST_WRESP; // accepted
                end
            end
            mem_bus_pkg::ST_WRESP: begin
                if (wr_resp) begin
                    state_nxt = mem_bus_pkg::ST_DONE;
                end
            end
            mem_bus_pkg::ST_DONE: begin
                state_nxt = mem_bus_pkg::ST_IDLE;
            end
            default: begin
                state_nxt = mem_bus_pkg::ST_IDLE;
            end
        endcase
    end

    // the bus sees zeros whenever no store is under way
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
            wr_data <= '0;
            wr_strb <= '0;
        end else begin
            case (state)
                mem_bus_pkg::ST_IDLE: begin
                    if (is_store) begin
                        wr_addr <= st_addr;
                        wr_data <= st_data;
                        wr_strb <= st_strb;
                    end
                end
                mem_bus_pkg::ST_DONE: begin
                    wr_addr <= '0;
                    wr_data <= '0;
                    wr_strb <= '0;
                end
                default: begin
                    // hold through write and response
                end
            endcase
        end
    end

    assign wr_req     = (state == mem_bus_pkg::ST_WRITE);
    assign store_done = (state == mem_bus_pkg::ST_DONE);
    assign store_busy = (state != mem_bus_pkg::ST_IDLE); // upstream holds stores

endmodule

/* hdl/wb_result.sv */
`timescale 1ns/100ps

module wb_result #(
    parameter int NUM_REGS = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              reg_wen,
    input  logic [rv_core_pkg::REG_IDX_W-1:0] rd,
    input  logic                              is_store,
    input  rv_core_pkg::res_src_e             res_src,
    input  logic                              fwd_hazard,
    input  logic [rv_core_pkg::XLEN-1:0]      ex_res,
    input  logic [rv_core_pkg::XLEN-1:0]      mem_res,
    input  rv_core_pkg::ext_kind_e            ext_kind,
    input  logic [rv_core_pkg::XLEN-1:0]      wb_pc,
    input  logic                              ebreak,

    output logic                              gpr_we,
    output logic [rv_core_pkg::REG_IDX_W-1:0] gpr_waddr,
    output logic [rv_core_pkg::XLEN-1:0]      gpr_wdata,
    output logic [rv_core_pkg::XLEN-1:0]      retire_pc,
    output logic                              halted
);

    logic [rv_core_pkg::XLEN-1:0] sel_res;
    logic                         rd_ok;

    // a forwarding hazard means the memory value is stale, keep ex
    assign sel_res = (res_src == rv_core_pkg::SRC_MEM && !fwd_hazard) ? mem_res : ex_res;

    always_comb begin
        gpr_wdata = sel_res;
        case (ext_kind)
            rv_core_pkg::EXT_SEXT_W: gpr_wdata = {{32{sel_res[31]}}, sel_res[31:0]};
            rv_core_pkg::EXT_ZEXT_W: gpr_wdata = {32'd0, sel_res[31:0]};
            rv_core_pkg::EXT_SEXT_H: gpr_wdata = {{48{sel_res[15]}}, sel_res[15:0]};
            default:                 gpr_wdata = sel_res;
        endcase
    end

    assign rd_ok     = (rd != '0) && (32'(rd) < NUM_REGS);
    assign gpr_waddr = rd;

    // stores never write a register, nothing writes once halted
    assign gpr_we = reg_wen && !is_store && rd_ok && !halted;

    // pc handed on for retirement one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_pc <= '0;
        end else begin
            retire_pc <= wb_pc;
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (ebreak) begin
            halted <= 1'b1;
        end
    end

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              reg_wen,
    input  logic [rv_core_pkg::REG_IDX_W-1:0] rd,
    input  logic                              is_store,
    input  rv_core_pkg::res_src_e             res_src,
    input  logic                              fwd_hazard,
    input  logic [rv_core_pkg::XLEN-1:0]      ex_res,
    input  logic [rv_core_pkg::XLEN-1:0]      mem_res,
    input  rv_core_pkg::ext_kind_e            ext_kind,
    input  logic [rv_core_pkg::REG_IDX_W-1:0] rs1,
    input  logic [31:0]                       st_imm,
    input  logic [rv_core_pkg::XLEN-1:0]      st_data,
    input  logic [mem_bus_pkg::STRB_W-1:0]    st_strb,
    input  logic [rv_core_pkg::XLEN-1:0]      wb_pc,
    input  logic                              ebreak,
    input  logic [rv_core_pkg::REG_IDX_W-1:0] dbg_raddr,
    input  logic                              wr_done,
    input  logic                              wr_resp,

    output logic [rv_core_pkg::XLEN-1:0]      dbg_rdata,
    output logic [rv_core_pkg::XLEN-1:0]      retire_pc,
    output logic                              halted,
    output logic                              store_busy,
    output logic                              wr_req,
    output logic [rv_core_pkg::XLEN-1:0]      wr_addr,
    output logic [rv_core_pkg::XLEN-1:0]      wr_data,
    output logic [mem_bus_pkg::STRB_W-1:0]    wr_strb,
    output logic                              store_done
);

    logic                              gpr_we;
    logic [rv_core_pkg::REG_IDX_W-1:0] gpr_waddr;
    logic [rv_core_pkg::XLEN-1:0]      gpr_wdata;
    logic [rv_core_pkg::XLEN-1:0]      rs1_data; // store base

    gpr_file #(
        .NUM_REGS (NUM_REGS)
    ) gpr_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (gpr_we),
        .waddr   (gpr_waddr),
        .wdata   (gpr_wdata),
        .raddr_a (rs1),
        .rdata_a (rs1_data),
        .raddr_b (dbg_raddr),
        .rdata_b (dbg_rdata)
    );

    wb_result #(
        .NUM_REGS (NUM_REGS)
    ) result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wen    (reg_wen),
        .rd         (rd),
        .is_store   (is_store),
        .res_src    (res_src),
        .fwd_hazard (fwd_hazard),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .ext_kind   (ext_kind),
        .wb_pc      (wb_pc),
        .ebreak     (ebreak),
        .gpr_we     (gpr_we),
        .gpr_waddr  (gpr_waddr),
        .gpr_wdata  (gpr_wdata),
        .retire_pc  (retire_pc),
        .halted     (halted)
    );

    store_writer store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .is_store   (is_store),
        .rs1_data   (rs1_data),
        .st_imm     (st_imm),
        .st_data    (st_data),
        .st_strb    (st_strb),
        .wr_done    (wr_done),
        .wr_resp    (wr_resp),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .store_done (store_done),
        .store_busy (store_busy)
    );

endmodule

/* run.sh */
#!/bin/sh
# build the writeback testbench with verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module wb_stage_tb -f src.f -o wb_stage_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/wb_stage_sim > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "RESULT: FAIL, no pass line"; exit 1; }
echo "RESULT: PASS"

/* src.f */
hdl/rv_core_pkg.sv
hdl/mem_bus_pkg.sv
hdl/gpr_file.sv
hdl/wb_result.sv
hdl/store_writer.sv
hdl/wb_stage.sv
tb/wb_stage_assert.sv
tb/wb_stage_checker.sv
tb/wb_stage_tb.sv

/* tb/wb_stage_assert.sv */
`timescale 1ns/100ps

module wb_stage_assert (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             wr_req,
    input logic [rv_core_pkg::XLEN-1:0]     wr_addr,
    input logic [rv_core_pkg::XLEN-1:0]     wr_data,
    input logic [mem_bus_pkg::STRB_W-1:0]   wr_strb,
    input logic                             store_done
);

    // payload frozen until the write is accepted
    req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_req && $past(wr_req)) |-> ($stable(wr_addr) && $stable(wr_data) && $stable(wr_strb)))
        else $error("write payload moved while wr_req was high");

    done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        store_done |=> !store_done)
        else $error("store_done held for more than one cycle");

    req_done_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_req && store_done))
        else $error("wr_req and store_done high in the same cycle");

endmodule

bind store_writer wb_stage_assert assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_strb    (wr_strb),
    .store_done (store_done)
);

/* tb/wb_stage_checker.sv */
`timescale 1ns/100ps

module wb_stage_checker #(
    parameter int NUM_REGS = 32
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              reg_wen,
    input logic [rv_core_pkg::REG_IDX_W-1:0] rd,
    input logic                              is_store,
    input rv_core_pkg::res_src_e             res_src,
    input logic                              fwd_hazard,
    input logic [rv_core_pkg::XLEN-1:0]      ex_res,
    input logic [rv_core_pkg::XLEN-1:0]      mem_res,
    input rv_core_pkg::ext_kind_e            ext_kind,
    input logic [rv_core_pkg::REG_IDX_W-1:0] rs1,
    input logic [31:0]                       st_imm,
    input logic [rv_core_pkg::XLEN-1:0]      st_data,
    input logic [mem_bus_pkg::STRB_W-1:0]    st_strb,
    input logic [rv_core_pkg::XLEN-1:0]      wb_pc,
    input logic                              ebreak,
    input logic [rv_core_pkg::REG_IDX_W-1:0] dbg_raddr,
    input logic                              wr_done,
    input logic                              wr_resp,
    input logic [rv_core_pkg::XLEN-1:0]      dbg_rdata,
    input logic [rv_core_pkg::XLEN-1:0]      retire_pc,
    input logic                              halted,
    input logic                              store_busy,
    input logic                              wr_req,
    input logic [rv_core_pkg::XLEN-1:0]      wr_addr,
    input logic [rv_core_pkg::XLEN-1:0]      wr_data,
    input logic [mem_bus_pkg::STRB_W-1:0]    wr_strb,
    input logic                              store_done,
    input int                                test_id
);

    localparam int LAST_TEST = 5;

    logic [rv_core_pkg::XLEN-1:0]   model_regs [2**rv_core_pkg::REG_IDX_W];
    logic                           model_halted;
    logic [rv_core_pkg::XLEN-1:0]   prev_pc;
    mem_bus_pkg::st_state_e         mst;        // where the bus should be
    logic [rv_core_pkg::XLEN-1:0]   exp_addr_q [$];
    logic [rv_core_pkg::XLEN-1:0]   exp_data_q [$];
    logic [mem_bus_pkg::STRB_W-1:0] exp_strb_q [$];

    int err_count   = 0;
    int check_count = 0;
    int tests_run   = 0;
    int tests_bad   = 0;
    int cur_test    = 0;
    int test_errs   = 0;
    int test_checks = 0;

    function automatic string test_name(input int id);
        case (id)
            1: return "after reset";
            2: return "register writes";
            3: return "dropped writes";
            4: return "random stores";
            5: return "ebreak halt";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [63:0] sext_word(input logic [31:0] v);
        return {v[31] ? 32'hffff_ffff : 32'h0, v};
    endfunction

    function automatic logic [63:0] shaped(input logic [63:0] v, input rv_core_pkg::ext_kind_e k);
        if (k == rv_core_pkg::EXT_SEXT_W) return sext_word(v[31:0]);
        if (k == rv_core_pkg::EXT_ZEXT_W) return {32'h0, v[31:0]};
        if (k == rv_core_pkg::EXT_SEXT_H) return {v[15] ? 48'hffff_ffff_ffff : 48'h0, v[15:0]};
        return v;
    endfunction

    function automatic logic [63:0] model_read(input logic [rv_core_pkg::REG_IDX_W-1:0] idx);
        return (32'(idx) < NUM_REGS) ? model_regs[idx] : '0; // x0 stays zero in the model
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            err_count++;
            test_errs++;
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic complain(input string what);
        err_count++;
        test_errs++;
        $display("error: %s at %0t", what, $time);
    endtask

    task automatic close_test();
        if (cur_test >= 1) begin
            if (test_id > LAST_TEST && exp_addr_q.size() != 0) begin
                complain("a store never completed before the end of the run");
            end
            $display("[%s] test %0d %s: %0d checks, %0d errors",
                     (test_errs == 0) ? "PASS" : "FAIL", cur_test, test_name(cur_test),
                     test_checks, test_errs);
            tests_run++;
            if (test_errs != 0) tests_bad++;
        end
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic clear_model();
        for (int i = 0; i < 2**rv_core_pkg::REG_IDX_W; i++) begin
            model_regs[i] = '0;
        end
        model_halted = 1'b0;
        prev_pc      = '0;
        mst          = mem_bus_pkg::ST_IDLE;
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_strb_q.delete();
    endtask

    task automatic compare_ports();
        check("dbg_rdata", dbg_rdata, model_read(dbg_raddr));
        check("retire_pc", retire_pc, prev_pc);
        check("halted", 64'(halted), 64'(model_halted));
        check("wr_req", 64'(wr_req), 64'(mst == mem_bus_pkg::ST_WRITE));
        check("store_busy", 64'(store_busy), 64'(mst != mem_bus_pkg::ST_IDLE));
        check("store_done", 64'(store_done), 64'(mst == mem_bus_pkg::ST_DONE));
        if (mst == mem_bus_pkg::ST_IDLE) begin
            check("wr_addr", wr_addr, '0); // idle bus is all zero
            check("wr_data", wr_data, '0);
            check("wr_strb", 64'(wr_strb), '0);
        end else if (mst != mem_bus_pkg::ST_DONE && exp_addr_q.size() != 0) begin
            check("wr_addr", wr_addr, exp_addr_q[0]);
            check("wr_data", wr_data, exp_data_q[0]);
            check("wr_strb", 64'(wr_strb), 64'(exp_strb_q[0]));
        end
    endtask

    task automatic step_model();
        logic [63:0] sel;
        // store side goes first as it reads the base before this cycle's write
        case (mst)
            mem_bus_pkg::ST_IDLE: begin
                if (wr_done || wr_resp) complain("bus response with no write pending");
                if (is_store) begin
                    exp_addr_q.push_back(model_read(rs1) + sext_word(st_imm));
                    exp_data_q.push_back(st_data);
                    exp_strb_q.push_back(st_strb);
                    mst = mem_bus_pkg::ST_WRITE;
                end
            end
            mem_bus_pkg::ST_WRITE: begin
                if (wr_resp) complain("wr_resp arrived before the write was accepted");
                if (wr_done) mst = mem_bus_pkg::ST_WRESP;
            end
            mem_bus_pkg::ST_WRESP: begin
                if (wr_done) complain("wr_done pulsed twice for one write");
                if (wr_resp) mst = mem_bus_pkg::ST_DONE;
            end
            default: begin
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_strb_q.pop_front());
                mst = mem_bus_pkg::ST_IDLE;
            end
        endcase
        sel = (res_src == rv_core_pkg::SRC_MEM && !fwd_hazard) ? mem_res : ex_res;
        if (reg_wen && !is_store && rd != '0 && 32'(rd) < NUM_REGS && !model_halted) begin
            model_regs[rd] = shaped(sel, ext_kind);
        end
        if (ebreak) model_halted = 1'b1;
        prev_pc = wb_pc;
    endtask

    // inputs settle half a cycle before this edge
    always @(posedge clk) begin
        if (test_id != cur_test) begin
            close_test();
            cur_test = test_id;
        end
        if (!rst_n) begin
            clear_model();
        end else begin
            compare_ports();
            step_model();
        end
    end

endmodule

/* tb/wb_stage_tb.sv */
`timescale 1ns/100ps

module wb_stage_tb;

    localparam int NUM_REGS    = 32;
    localparam int RST_CYCLES  = 8;
    localparam int N_WRITES    = 400;
    localparam int N_DROPS     = 200;
    localparam int N_STORES    = 400;
    localparam int N_HALT      = 120;
    localparam int N_TRANS     = N_WRITES + N_DROPS + N_STORES + N_HALT + 2 * 32 + 21;
    localparam int WORST_STORE = 11; // take, 4 to accept, 4 to ack, done, idle
    localparam int LIMIT       = N_TRANS * WORST_STORE + 200;

    logic                              clk;
    logic                              rst_n;
    logic                              reg_wen;
    logic [rv_core_pkg::REG_IDX_W-1:0] rd;
    logic                              is_store;
    rv_core_pkg::res_src_e             res_src;
    logic                              fwd_hazard;
    logic [rv_core_pkg::XLEN-1:0]      ex_res;
    logic [rv_core_pkg::XLEN-1:0]      mem_res;
    rv_core_pkg::ext_kind_e            ext_kind;
    logic [rv_core_pkg::REG_IDX_W-1:0] rs1;
    logic [31:0]                       st_imm;
    logic [rv_core_pkg::XLEN-1:0]      st_data;
    logic [mem_bus_pkg::STRB_W-1:0]    st_strb;
    logic [rv_core_pkg::XLEN-1:0]      wb_pc;
    logic                              ebreak;
    logic [rv_core_pkg::REG_IDX_W-1:0] dbg_raddr;
    logic                              wr_done;
    logic                              wr_resp;
    logic [rv_core_pkg::XLEN-1:0]      dbg_rdata;
    logic [rv_core_pkg::XLEN-1:0]      retire_pc;
    logic                              halted;
    logic                              store_busy;
    logic                              wr_req;
    logic [rv_core_pkg::XLEN-1:0]      wr_addr;
    logic [rv_core_pkg::XLEN-1:0]      wr_data;
    logic [mem_bus_pkg::STRB_W-1:0]    wr_strb;
    logic                              store_done;

    int                                seed;
    int                                test_id;
    int                                resp_phase; // 0 idle, 1 before accept, 2 before ack
    int                                resp_wait;
    logic [rv_core_pkg::REG_IDX_W-1:0] last_rd;

    wb_stage #(.NUM_REGS (NUM_REGS)) dut_i (.*);

    wb_stage_checker #(.NUM_REGS (NUM_REGS)) chk_i (.*);

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = rnd();
        return (r % 32'd100) < 32'(pct);
    endfunction

    task automatic idle_inputs();
        reg_wen    = 1'b0;
        rd         = '0;
        is_store   = 1'b0;
        res_src    = rv_core_pkg::SRC_EX;
        fwd_hazard = 1'b0;
        ex_res     = '0;
        mem_res    = '0;
        ext_kind   = rv_core_pkg::EXT_NONE;
        rs1        = '0;
        st_imm     = '0;
        st_data    = '0;
        st_strb    = '0;
        wb_pc      = '0;
        ebreak     = 1'b0;
        dbg_raddr  = '0;
    endtask

    // memory side accepts, then acks, each after 0 to 3 idle cycles
    task automatic respond_bus();
        logic [31:0] r;
        r       = rnd();
        wr_done = 1'b0;
        wr_resp = 1'b0;
        if (resp_phase == 0 && wr_req) begin
            resp_wait  = int'(r[1:0]);
            resp_phase = 1;
        end else if (resp_phase == 2) begin
            if (resp_wait == 0) begin
                wr_resp    = 1'b1;
                resp_phase = 0;
            end else begin
                resp_wait--;
            end
        end
        if (resp_phase == 1) begin
            if (resp_wait == 0) begin
                wr_done    = 1'b1;
                resp_wait  = int'(r[3:2]);
                resp_phase = 2;
            end else begin
                resp_wait--;
            end
        end
    endtask

    task automatic drive_cycle(input int store_pct, input int zero_pct, input bit busy_stores);
        logic [31:0] r;
        reg_wen = chance(80);
        r       = rnd();
        rd      = chance(zero_pct) ? '0 : r[rv_core_pkg::REG_IDX_W-1:0];
        if (store_busy) begin
            is_store = busy_stores && chance(15); // must be ignored by the DUT
        end else begin
            is_store = chance(store_pct);
        end
        r          = rnd();
        res_src    = rv_core_pkg::res_src_e'(r[0]);
        fwd_hazard = r[1] & r[2];
        ext_kind   = rv_core_pkg::ext_kind_e'(r[4:3]);
        rs1        = r[12:8];
        st_strb    = r[23:16];
        ex_res     = {rnd(), rnd()};
        mem_res    = {rnd(), rnd()};
        st_imm     = rnd();
        st_data    = {rnd(), rnd()};
        wb_pc      = {rnd(), rnd()};
        ebreak     = 1'b0;
        r          = rnd();
        dbg_raddr  = r[0] ? last_rd : r[12:8]; // often the register just written
        last_rd    = rd;
    endtask

    task automatic run_cycles(input int n, input int store_pct, input int zero_pct,
                              input bit busy_stores);
        repeat (n) begin
            respond_bus();
            drive_cycle(store_pct, zero_pct, busy_stores);
            @(negedge clk);
        end
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 2**rv_core_pkg::REG_IDX_W; i++) begin
            respond_bus();
            idle_inputs();
            dbg_raddr = i[rv_core_pkg::REG_IDX_W-1:0];
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", LIMIT);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed       = 32'hcb0c;
        test_id    = 0;
        resp_phase = 0;
        resp_wait  = 0;
        last_rd    = '0;
        wr_done    = 1'b0;
        wr_resp    = 1'b0;
        rst_n      = 1'b0;
        idle_inputs();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_id = 1;
        sweep_regs();
        test_id = 2;
        run_cycles(N_WRITES, 0, 0, 1'b0);
        test_id = 3;
        run_cycles(N_DROPS, 30, 50, 1'b0);
        test_id = 4;
        run_cycles(N_STORES, 40, 5, 1'b1);
        test_id = 5;
        run_cycles(20, 10, 0, 1'b0);
        respond_bus();
        drive_cycle(10, 0, 1'b0);
        ebreak = 1'b1;
        @(negedge clk);
        run_cycles(N_HALT, 10, 10, 1'b0);
        sweep_regs();

        // let the last store finish
        idle_inputs();
        while (store_busy) begin
            respond_bus();
            @(negedge clk);
        end
        test_id = 6;
        repeat (2) @(negedge clk);

        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 chk_i.tests_run, chk_i.tests_bad, chk_i.check_count, chk_i.err_count);
        if (chk_i.err_count == 0 && chk_i.tests_run == 5) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
